// File: rtl/fm_pkg.sv
////////////////////////////////////////
// fm operator shared definitions
// frame timing, word widths, fsm states
////////////////////////////////////////

package fm_pkg;

  ////////////////////////////////////////
  // frame timing

  localparam int frame_len = 144;          // clocks per sample slot
  localparam int pg_slot   = 1;            // phase and envelope strobe count
  localparam int conv_slot = 4;            // converter read strobe count

  ////////////////////////////////////////
  // word widths

  localparam int phase_w   = 20;           // phase accumulator
  localparam int log_w     = 14;           // log attenuation, lsb is sign
  localparam int amp_w     = 14;           // linear sample, two's complement
  localparam int sine_len  = 1024;         // log-sine table depth
  localparam int exp_len   = 256;          // exponential table depth

  localparam logic [6:0] env_max = 7'd127; // 1/8 octave units

  localparam real fm_pi = 3.14159265358979;

  ////////////////////////////////////////
  // state encodings

  typedef enum logic [2:0] {
    eg_idle,
    eg_attack,
    eg_decay,
    eg_sustain,
    eg_release
  } eg_state_t;

  typedef enum logic [2:0] {
    cv_input,
    cv_lut,
    cv_shift,
    cv_sign,
    cv_output
  } conv_state_t;

endpackage

// File: rtl/fm_slot_sequencer.sv
////////////////////////////////////////
// fm slot sequencer
// frame counter and per-frame strobes
////////////////////////////////////////

`timescale 1ns/1ps

module fm_slot_sequencer (
  input  logic clk,
  input  logic reset_n,
  output logic pg_ce,
  output logic eg_ce,
  output logic conv_rd
);
  import fm_pkg::*;

  logic [7:0] count;                       // position inside the frame

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count   <= 8'd0;
      pg_ce   <= 1'b0;
      eg_ce   <= 1'b0;
      conv_rd <= 1'b0;
    end else begin
      if (count == 8'(frame_len - 1))
        count <= 8'd0;                     // wrap at end of frame
      else
        count <= count + 8'd1;
      pg_ce   <= (count == 8'(pg_slot));   // high during pg_slot + 1
      eg_ce   <= (count == 8'(pg_slot));
      conv_rd <= (count == 8'(conv_slot)); // high during conv_slot + 1
    end
  end

  count_in_frame_a : assert property (@(posedge clk) disable iff (!reset_n)
    count <= 8'(frame_len - 1));

endmodule

// File: rtl/fm_phase_gen.sv
////////////////////////////////////////
// fm phase generator
// 20-bit accumulator, one step per frame
////////////////////////////////////////

`timescale 1ns/1ps

module fm_phase_gen (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        pg_ce,
  input  logic [10:0] fnumber,
  input  logic [2:0]  block,
  input  logic [3:0]  multiple,
  output logic [9:0]  phase
);
  import fm_pkg::*;

  logic [phase_w-1:0] acc;
  logic [phase_w-1:0] base_step;
  logic [phase_w-1:0] step;

  // fnumber scaled by octave, then halved
  assign base_step = ({{(phase_w - 11){1'b0}}, fnumber} << block) >> 1;

  always_comb begin
    if (multiple == 4'd0)
      step = base_step >> 1;               // multiple 0 means x0.5
    else
      step = base_step * {{(phase_w - 4){1'b0}}, multiple};
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      acc <= '0;
    else if (pg_ce)
      acc <= acc + step;                   // wraps at 2^20
  end

  assign phase = acc[phase_w-1 -: 10];     // top bits address the sine

endmodule

// File: rtl/fm_envelope_gen.sv
////////////////////////////////////////
// fm envelope generator
// attack, decay, sustain, release fsm
////////////////////////////////////////

`timescale 1ns/1ps

module fm_envelope_gen (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       eg_ce,
  input  logic       key_on,
  input  logic       key_off,
  input  logic [5:0] ar,                   // attack rate
  input  logic [5:0] dr,                   // decay rate
  input  logic [5:0] sr,                   // sustain rate
  input  logic [3:0] rr,                   // release rate
  input  logic [3:0] sl,                   // sustain level
  input  logic [6:0] total_level,
  output logic [6:0] env
);
  import fm_pkg::*;

  eg_state_t  state;
  logic [6:0] sus_lvl;                     // latched at key_on
  logic [7:0] sl_sum;
  logic [7:0] rate;
  logic [7:0] env_up;
  logic [7:0] env_dn;
  logic       attack_over;

  // per-state step size
  always_comb begin
    case (state)
      eg_attack:  rate = {1'b0, ar, ar[0]};
      eg_decay:   rate = {1'b0, dr, dr[0]};
      eg_sustain: rate = {1'b0, sr, sr[0]};
      eg_release: rate = {1'b0, rr, 3'b000};
      default:    rate = 8'd0;
    endcase
  end

  assign sl_sum      = {2'b00, sl, 2'b00} + {1'b0, total_level};
  assign env_up      = {1'b0, env} + rate;
  assign env_dn      = {1'b0, env} - rate;
  assign attack_over = env_dn[7] || (env_dn[6:0] <= total_level); // borrow is a wrap

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state   <= eg_idle;
      env     <= env_max;
      sus_lvl <= env_max;
    end else begin
      case (state)
        eg_idle: begin
          env <= env_max;
          if (key_on) begin
            state   <= eg_attack;
            sus_lvl <= (sl_sum > {1'b0, env_max}) ? env_max : sl_sum[6:0];
          end
        end
        eg_attack:
          if (key_off)
            state <= eg_release;
          else if (eg_ce) begin
            if (attack_over) begin
              env   <= total_level;        // peak reached
              state <= eg_decay;
            end else
              env <= env_dn[6:0];
          end
        eg_decay:
          if (key_off)
            state <= eg_release;
          else if (eg_ce) begin
            if (env_up >= {1'b0, sus_lvl}) begin
              env   <= sus_lvl;
              state <= eg_sustain;
            end else
              env <= env_up[6:0];
          end
        eg_sustain:
          if (key_off)
            state <= eg_release;
          else if (eg_ce) begin
            if (env_up >= {1'b0, env_max}) begin
              env   <= env_max;            // faded out
              state <= eg_idle;
            end else
              env <= env_up[6:0];
          end
        eg_release:
          if (eg_ce) begin
            if (env_up >= {1'b0, env_max}) begin
              env   <= env_max;
              state <= eg_idle;
            end else
              env <= env_up[6:0];
          end
        default: begin
          state <= eg_idle;
          env   <= env_max;
        end
      endcase
    end
  end

  idle_is_silent_a : assert property (@(posedge clk) disable iff (!reset_n)
    state == eg_idle |-> env == env_max);

endmodule

// File: rtl/fm_log_sine.sv
////////////////////////////////////////
// fm log-sine lookup
// sine attenuation plus envelope, saturated
////////////////////////////////////////

`timescale 1ns/1ps

module fm_log_sine (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic [9:0]               phase,
  input  logic [6:0]               env,
  output logic [fm_pkg::log_w-1:0] log_val
);
  import fm_pkg::*;

  logic [log_w-2:0] sine_table [0:sine_len-1]; // {atten[11:0], sign}
  logic [9:0]       phase_q;
  logic [log_w-2:0] entry;
  logic [log_w-1:0] mag_sum;               // one spare bit for overflow

  // table contents from the log-sine formula
  initial begin
    real s;
    real att;
    int  att_i;
    for (int p = 0; p < sine_len; p++) begin
      s = $sin((p + 0.5) * 2.0 * fm_pi / sine_len);
      if (s < 0.0)
        s = -s;
      att   = -256.0 * $ln(s) / $ln(2.0);
      att_i = $rtoi(att + 0.5);
      if (att_i > 4095)
        att_i = 4095;
      sine_table[p] = {att_i[11:0], (p >= sine_len / 2)};
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      phase_q <= 10'd0;
    else
      phase_q <= phase;
  end

  assign entry = sine_table[phase_q];

  // env unit is 1/8 octave, 32 magnitude steps
  assign mag_sum = {2'b00, entry[log_w-2:1]} + {2'b00, env, 5'b00000};

  always_comb begin
    if (mag_sum[log_w-1])
      log_val = {{(log_w - 1){1'b1}}, entry[0]}; // saturate, keep sign
    else
      log_val = {mag_sum[log_w-2:0], entry[0]};
  end

endmodule

// File: rtl/fm_exp_conv.sv
////////////////////////////////////////
// fm exponential converter
// log attenuation back to linear sample
////////////////////////////////////////

`timescale 1ns/1ps

module fm_exp_conv (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     conv_rd,
  input  logic [fm_pkg::log_w-1:0] log_val,
  output logic [fm_pkg::amp_w-1:0] linear,
  output logic                     sample_strobe
);
  import fm_pkg::*;

  conv_state_t       state;
  logic [12:0]       exp_table [0:exp_len-1]; // 2^(-i/256) scaled to 8191
  logic [4:0]        exponent;             // whole octaves
  logic [7:0]        index;                // octave fraction
  logic              sign;
  logic [12:0]       raw;
  logic [12:0]       shifted;
  logic [amp_w-1:0]  signed_val;

  initial begin
    real v;
    int  v_i;
    for (int i = 0; i < exp_len; i++) begin
      v            = 8191.0 * $pow(2.0, -i / 256.0);
      v_i          = $rtoi(v + 0.5);
      exp_table[i] = v_i[12:0];
    end
  end

  ////////////////////////////////////////
  // datapath registers

  always_ff @(posedge clk) begin
    if (state == cv_input && conv_rd) begin
      exponent <= log_val[13:9];
      index    <= log_val[8:1];
      sign     <= log_val[0];
    end
    if (state == cv_lut)
      raw <= exp_table[index];
    if (state == cv_shift)
      shifted <= raw >> exponent;
  end

  // two's complement when the sign bit is set
  assign signed_val = sign ? -{1'b0, shifted} : {1'b0, shifted};

  ////////////////////////////////////////
  // control

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= cv_input;
      linear        <= '0;
      sample_strobe <= 1'b0;
    end else begin
      sample_strobe <= 1'b0;
      case (state)
        cv_input:
          if (conv_rd)
            state <= cv_lut;               // fields latched this edge
        cv_lut:   state <= cv_shift;
        cv_shift: state <= cv_sign;
        cv_sign: begin
          linear        <= signed_val;     // fourth edge after conv_rd
          sample_strobe <= 1'b1;
          state         <= cv_output;
        end
        cv_output: state <= cv_input;      // sample shown, back to idle
        default:   state <= cv_input;
      endcase
    end
  end

  // strobe only for a read accepted four edges earlier
  strobe_after_read_a : assert property (@(posedge clk) disable iff (!reset_n)
    sample_strobe |-> $past(conv_rd, 4));

endmodule

// File: rtl/fm_operator.sv
////////////////////////////////////////
// fm operator slot top level
////////////////////////////////////////

`timescale 1ns/1ps

module fm_operator (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic [10:0]              fnumber,
  input  logic [2:0]               block,
  input  logic [3:0]               multiple,
  input  logic                     key_on,
  input  logic                     key_off,
  input  logic [5:0]               ar,
  input  logic [5:0]               dr,
  input  logic [5:0]               sr,
  input  logic [3:0]               rr,
  input  logic [3:0]               sl,
  input  logic [6:0]               total_level,
  output logic [fm_pkg::amp_w-1:0] linear,
  output logic                     sample_strobe
);
  import fm_pkg::*;

  logic             pg_ce;
  logic             eg_ce;
  logic             conv_rd;
  logic [9:0]       phase;
  logic [6:0]       env;
  logic [log_w-1:0] log_val;               // sine plus envelope, log domain

  fm_slot_sequencer fm_slot_sequencer_i (
    .clk     (clk),
    .reset_n (reset_n),
    .pg_ce   (pg_ce),
    .eg_ce   (eg_ce),
    .conv_rd (conv_rd)
  );

  fm_phase_gen fm_phase_gen_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .pg_ce    (pg_ce),
    .fnumber  (fnumber),
    .block    (block),
    .multiple (multiple),
    .phase    (phase)
  );

  fm_envelope_gen fm_envelope_gen_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .eg_ce       (eg_ce),
    .key_on      (key_on),
    .key_off     (key_off),
    .ar          (ar),
    .dr          (dr),
    .sr          (sr),
    .rr          (rr),
    .sl          (sl),
    .total_level (total_level),
    .env         (env)
  );

  fm_log_sine fm_log_sine_i (
    .clk     (clk),
    .reset_n (reset_n),
    .phase   (phase),
    .env     (env),
    .log_val (log_val)
  );

  fm_exp_conv fm_exp_conv_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .conv_rd       (conv_rd),
    .log_val       (log_val),
    .linear        (linear),
    .sample_strobe (sample_strobe)
  );

endmodule

// File: tb/fm_operator_checker.sv
////////////////////////////////////////
// fm operator checker
// reference model and sample compare
////////////////////////////////////////

`timescale 1ns/1ps

module fm_operator_checker (
  input  logic        clk,
  input  logic        reset_n,
  input  logic [10:0] fnumber,
  input  logic [2:0]  block,
  input  logic [3:0]  multiple,
  input  logic        key_on,
  input  logic        key_off,
  input  logic [5:0]  ar,
  input  logic [5:0]  dr,
  input  logic [5:0]  sr,
  input  logic [3:0]  rr,
  input  logic [3:0]  sl,
  input  logic [6:0]  total_level,
  input  logic [13:0] linear,
  input  logic        sample_strobe,
  input  logic [2:0]  test_id,
  input  logic        test_end,
  output int          errors_total,
  output int          samples_total,
  output int          tests_run,
  output int          tests_failed
);
  import fm_pkg::*;

  localparam int step_count   = pg_slot + 1;    // pg_ce and eg_ce high
  localparam int read_count   = conv_slot + 1;  // conv_rd high
  localparam int strobe_count = read_count + 4;

  int          sine_att [0:sine_len-1];
  int          exp_lut  [0:exp_len-1];
  int          m_count;                    // model frame position
  int unsigned acc;
  eg_state_t   eg_state;
  int          env;
  int          sus_lvl;
  int          exp_phase;
  int          exp_env;
  logic [13:0] expected;
  bit          strobe_seen;
  int          err_cnt      = 0;
  int          smp_cnt      = 0;
  int          test_cnt     = 0;
  int          fail_cnt     = 0;
  int          test_err     = 0;
  int          test_samples = 0;

  assign errors_total  = err_cnt;
  assign samples_total = smp_cnt;
  assign tests_run     = test_cnt;
  assign tests_failed  = fail_cnt;

  initial begin
    real s;
    int  a;
    for (int p = 0; p < sine_len; p++) begin
      s = $sin((p + 0.5) * 2.0 * fm_pi / sine_len);
      if (s < 0.0)
        s = -s;
      a = $rtoi(-256.0 * $ln(s) / $ln(2.0) + 0.5);
      sine_att[p] = (a > 4095) ? 4095 : a;
    end
    for (int i = 0; i < exp_len; i++)
      exp_lut[i] = $rtoi(8191.0 * $pow(2.0, -real'(i) / 256.0) + 0.5);
  end

  ////////////////////////////////////////
  // reference arithmetic

  function automatic logic [13:0] expected_linear(input int ph, input int att_env);
    int mag;
    int amp;
    mag = sine_att[ph] + att_env * 32;
    if (mag > 8191)
      mag = 8191;                          // magnitude clamps to all ones
    amp = exp_lut[mag % 256] >> (mag / 256);
    if (ph >= sine_len / 2)
      amp = -amp;                          // lower half of the wave
    return 14'(amp);
  endfunction

  function automatic int unsigned phase_step(input logic [10:0] fnum, input logic [2:0] blk,
                                             input logic [3:0] mul);
    int unsigned base;
    base = (32'(fnum) << blk) >> 1;
    if (mul == 4'd0)
      return base >> 1;
    return base * 32'(mul);
  endfunction

  task automatic envelope_update(input bit eg);
    int nxt;
    case (eg_state)
      eg_idle: begin
        env = int'(env_max);
        if (key_on) begin
          eg_state = eg_attack;
          sus_lvl  = 4 * int'(sl) + int'(total_level);
          if (sus_lvl > 127)
            sus_lvl = 127;
        end
      end
      eg_attack:
        if (key_off)
          eg_state = eg_release;
        else if (eg) begin
          nxt = env - (2 * int'(ar) + int'(ar[0]));
          if (nxt <= int'(total_level)) begin // also covers a wrap below zero
            env      = int'(total_level);
            eg_state = eg_decay;
          end else
            env = nxt;
        end
      eg_decay:
        if (key_off)
          eg_state = eg_release;
        else if (eg) begin
          nxt = env + 2 * int'(dr) + int'(dr[0]);
          env = (nxt >= sus_lvl) ? sus_lvl : nxt;
          if (nxt >= sus_lvl)
            eg_state = eg_sustain;
        end
      eg_sustain:
        if (key_off)
          eg_state = eg_release;
        else if (eg) begin
          nxt = env + 2 * int'(sr) + int'(sr[0]);
          env = (nxt >= 127) ? 127 : nxt;
          if (nxt >= 127)
            eg_state = eg_idle;
        end
      default:
        if (eg) begin
          nxt = env + 8 * int'(rr);        // release
          env = (nxt >= 127) ? 127 : nxt;
          if (nxt >= 127)
            eg_state = eg_idle;
        end
    endcase
  endtask

  ////////////////////////////////////////
  // per-test bookkeeping

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "reset state";
      3'd2:    return "silent idle";
      3'd3:    return "tone generation";
      3'd4:    return "full envelope";
      3'd5:    return "release to idle";
      3'd6:    return "saturation";
      default: return "unnamed";
    endcase
  endfunction

  task automatic note_error();
    err_cnt++;
    test_err++;
  endtask

  task automatic report_test();
    test_cnt++;
    if (test_samples == 0)
      $display("test %0d %s: no samples were delivered", test_id, test_name(test_id));
    if (test_err != 0 || test_samples == 0)
      fail_cnt++;
    $display("test %0d %s: %s, %0d samples, %0d errors", test_id, test_name(test_id),
             (test_err == 0 && test_samples != 0) ? "ok" : "failed", test_samples, test_err);
    test_err     = 0;
    test_samples = 0;
  endtask

  ////////////////////////////////////////
  // model and compare, one pass per clock

  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      m_count     = 0;
      acc         = 0;
      eg_state    = eg_idle;
      env         = int'(env_max);
      sus_lvl     = int'(env_max);
      expected    = '0;
      strobe_seen = 1'b0;
    end else begin
      // outputs held through the cycle that ends here
      if (m_count == strobe_count) begin
        if (!sample_strobe) begin
          $display("%0t: sample strobe missing at frame count %0d", $time, m_count);
          note_error();
        end else begin
          strobe_seen = 1'b1;
          smp_cnt++;
          test_samples++;
          if (linear !== expected) begin
            $display("CHECK FAILED %0t: linear %0d, expected %0d (phase %0d, env %0d)",
                     $time, $signed(linear), $signed(expected), exp_phase, exp_env);
            note_error();
          end
        end
      end else if (sample_strobe) begin
        $display("%0t: sample strobe came at frame count %0d", $time, m_count);
        note_error();
      end else if (!strobe_seen && linear !== '0) begin
        $display("CHECK FAILED %0t: linear %0d before the first sample, expected 0",
                 $time, $signed(linear));
        note_error();
      end

      if (m_count == read_count) begin
        exp_phase = int'(acc >> 10);       // top 10 accumulator bits
        exp_env   = env;
        expected  = expected_linear(exp_phase, exp_env);
      end
      if (m_count == step_count)
        acc = (acc + phase_step(fnumber, block, multiple)) & 32'h000f_ffff;
      envelope_update(m_count == step_count);
      m_count = (m_count == frame_len - 1) ? 0 : m_count + 1;
      if (test_end)
        report_test();
    end
  end

endmodule

// File: tb/fm_operator_tb.sv
////////////////////////////////////////
// fm operator testbench
// clock, reset, stimulus and watchdog
////////////////////////////////////////

`timescale 1ns/1ps

module fm_operator_tb;
  import fm_pkg::*;

  localparam int clk_period   = 20;
  localparam int reset_cycles = 16;
  localparam int tone_count   = 5;         // random tone settings
  localparam int tone_frames  = 6;         // samples per tone setting
  localparam int total_frames = 3 + 8 + (tone_count * tone_frames + 3) + 40 + 32 + 8;
  localparam int watchdog_ns  = (reset_cycles + (total_frames + 10) * frame_len) * clk_period;

  logic        clk;
  logic        reset_n;
  logic [10:0] fnumber;
  logic [2:0]  block;
  logic [3:0]  multiple;
  logic        key_on;
  logic        key_off;
  logic [5:0]  ar;
  logic [5:0]  dr;
  logic [5:0]  sr;
  logic [3:0]  rr;
  logic [3:0]  sl;
  logic [6:0]  total_level;
  logic [13:0] linear;
  logic        sample_strobe;
  logic [2:0]  test_id;
  logic        test_end;
  int          errors_total;
  int          samples_total;
  int          tests_run;
  int          tests_failed;
  int unsigned lcg_state = 32'd96322;

  fm_operator fm_operator_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .fnumber       (fnumber),
    .block         (block),
    .multiple      (multiple),
    .key_on        (key_on),
    .key_off       (key_off),
    .ar            (ar),
    .dr            (dr),
    .sr            (sr),
    .rr            (rr),
    .sl            (sl),
    .total_level   (total_level),
    .linear        (linear),
    .sample_strobe (sample_strobe)
  );

  fm_operator_checker fm_operator_checker_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .fnumber       (fnumber),
    .block         (block),
    .multiple      (multiple),
    .key_on        (key_on),
    .key_off       (key_off),
    .ar            (ar),
    .dr            (dr),
    .sr            (sr),
    .rr            (rr),
    .sl            (sl),
    .total_level   (total_level),
    .linear        (linear),
    .sample_strobe (sample_strobe),
    .test_id       (test_id),
    .test_end      (test_end),
    .errors_total  (errors_total),
    .samples_total (samples_total),
    .tests_run     (tests_run),
    .tests_failed  (tests_failed)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired, the DUT did not deliver all samples in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // stimulus helpers

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic wait_samples(input int n);
    repeat (n) begin
      do begin
        @(posedge clk);
      end while (!sample_strobe);
    end
  endtask

  task automatic pulse_key(input bit on);
    if (on)
      key_on <= 1'b1;
    else
      key_off <= 1'b1;
    @(posedge clk);
    key_on  <= 1'b0;
    key_off <= 1'b0;
  endtask

  task automatic set_envelope(input logic [5:0] a, input logic [5:0] d, input logic [5:0] s,
                              input logic [3:0] r, input logic [3:0] l, input logic [6:0] tl);
    ar          <= a;
    dr          <= d;
    sr          <= s;
    rr          <= r;
    sl          <= l;
    total_level <= tl;
  endtask

  task automatic finish_test();
    test_end <= 1'b1;
    @(posedge clk);
    test_end <= 1'b0;
  endtask

  ////////////////////////////////////////
  // test sequence

  initial begin
    int unsigned r;
    reset_n     = 1'b0;
    fnumber     = '0;
    block       = '0;
    multiple    = '0;
    key_on      = 1'b0;
    key_off     = 1'b0;
    ar          = '0;
    dr          = '0;
    sr          = '0;
    rr          = '0;
    sl          = '0;
    total_level = '0;
    test_id     = 3'd1;
    test_end    = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset_n <= 1'b1;
    wait_samples(3);                       // first strobes after reset
    finish_test();

    test_id <= 3'd2;
    r = lcg_next();
    fnumber  <= r[26:16];
    block    <= r[10:8];
    multiple <= r[3:0];
    wait_samples(8);
    finish_test();

    test_id <= 3'd3;
    set_envelope(6'd63, 6'd63, 6'd0, 4'd15, 4'd0, 7'd0); // straight to full level
    pulse_key(1'b1);
    for (int i = 0; i < tone_count; i++) begin
      r = lcg_next();
      fnumber  <= r[26:16];
      block    <= r[10:8];
      multiple <= (i == 2) ? 4'd0 : r[3:0];
      wait_samples(tone_frames);
    end
    pulse_key(1'b0);
    wait_samples(3);
    finish_test();

    test_id  <= 3'd4;
    fnumber  <= 11'd600;
    block    <= 3'd4;
    multiple <= 4'd2;
    set_envelope(6'd5, 6'd3, 6'd2, 4'd8, 4'd5, 7'd8);
    pulse_key(1'b1);
    wait_samples(40);                      // attack, decay, sustain, idle
    finish_test();

    test_id <= 3'd5;
    set_envelope(6'd63, 6'd1, 6'd0, 4'd3, 4'd15, 7'd4);
    pulse_key(1'b1);
    wait_samples(6);
    pulse_key(1'b0);                       // still in decay
    wait_samples(8);
    set_envelope(6'd63, 6'd63, 6'd0, 4'd1, 4'd15, 7'd4);
    pulse_key(1'b1);
    wait_samples(6);
    pulse_key(1'b0);                       // held in sustain
    wait_samples(12);
    finish_test();

    test_id <= 3'd6;
    set_envelope(6'd63, 6'd63, 6'd0, 4'd15, 4'd15, 7'd127);
    pulse_key(1'b1);
    wait_samples(8);
    finish_test();

    @(posedge clk);
    $display("tests %0d, failed %0d, samples %0d, errors %0d",
             tests_run, tests_failed, samples_total, errors_total);
    if (tests_failed == 0 && errors_total == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: src.f
rtl/fm_pkg.sv
rtl/fm_slot_sequencer.sv
rtl/fm_phase_gen.sv
rtl/fm_envelope_gen.sv
rtl/fm_log_sine.sv
rtl/fm_exp_conv.sv
rtl/fm_operator.sv
tb/fm_operator_checker.sv
tb/fm_operator_tb.sv

// File: Makefile
# Verilator simulation of the fm operator slot

VERILATOR ?= verilator
TOP       ?= fm_operator_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
